//--- hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    // read port widths
    localparam int addr_w = 48;             // byte address
    localparam int data_w = 64;             // one read beat
    localparam int resp_w = 2;

    localparam logic [resp_w-1:0] resp_okay = 2'd0; // anything else is a bus fault

    // page geometry
    localparam int page_bytes = 4096;
    localparam int page_sh    = 12;         // log2 of page_bytes

    // a page is fetched as whole cache lines
    localparam int beat_bytes     = 64;
    localparam int beats_per_page = 64;     // page_bytes / beat_bytes
    localparam int beat_cnt_w     = 7;      // counts 0 .. beats_per_page inclusive

    typedef logic [addr_w-1:0]         addr_t;
    typedef logic [addr_w-page_sh-1:0] way_t;  // page number, byte address >> page_sh

endpackage

//--- hdl/cmpresn_pkg.sv
package cmpresn_pkg;

    // compressor result
    localparam int size_w = 14;             // compressed size in bytes

    // zspages are grouped by size class, one class per 512 bytes of size
    localparam int size_class_bytes = 512;
    localparam int size_class_count = 8;
    localparam int class_w          = 3;

    typedef logic [class_w-1:0] class_t;

    // attribute table
    localparam int att_id_w = 16;

    typedef logic [att_id_w-1:0] att_id_t;

    // a fresh zspage keeps its metadata in the first bytes of the way
    localparam int zs_offset = 64;

    // list an entry lives on
    typedef enum logic [1:0] {
        list_uncomp,                        // waiting for compression
        list_incomp,                        // compressor gave up
        list_ifl                            // stored in a zspage
    } list_t;

    // list entry as returned by a head read
    localparam int ent_way_w   = 36;        // bits 35..0 hold the way
    localparam int ent_att_lsb = 36;        // bits 51..36 hold the attribute id

endpackage

//--- hdl/page_read_ctr.sv
module page_read_ctr (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear,         // restart on a new page
    input  mem_bus_pkg::way_t  base_way,
    input  logic               ar_ready,
    input  logic               rdfifo_full,
    input  logic               rdfifo_empty,
    output logic               beat_ar_valid,
    output mem_bus_pkg::addr_t beat_ar_addr,
    output logic               last           // all beats of the page issued
);
    import mem_bus_pkg::*;

    logic [beat_cnt_w-1:0] cnt_q;             // beats issued so far
    addr_t                 addr_q;            // address of the next beat
    logic                  valid_q;           // strobe seen last cycle

    assign last = (cnt_q == beat_cnt_w'(beats_per_page));

    // first beat waits for a drained fifo, later ones only need room
    assign beat_ar_valid = !clear && !last && ar_ready && !valid_q && !rdfifo_full &&
                           ((cnt_q != '0) || rdfifo_empty);
    assign beat_ar_addr  = addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q   <= beat_cnt_w'(beats_per_page); // idle counter reads as finished
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_ar_valid;
            if (clear) begin
                cnt_q <= '0;
            end else if (beat_ar_valid) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear) begin
            addr_q <= {base_way, {page_sh{1'b0}}}; // page base
        end else if (beat_ar_valid) begin
            addr_q <= addr_q + addr_t'(beat_bytes); // next cache line
        end
    end

    // back-pressure: a full fifo freezes the beat count
    a_hold_on_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
        rdfifo_full && !clear |=> cnt_q == $past(cnt_q));

endmodule

//--- hdl/uc_way_table.sv
module uc_way_table (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  cmpresn_pkg::class_t lookup_class,  // also selects the entry written
    input  logic                write,
    input  mem_bus_pkg::addr_t  write_base,
    input  mem_bus_pkg::addr_t  write_fill,
    output logic                valid,
    output mem_bus_pkg::addr_t  base,
    output mem_bus_pkg::addr_t  fill
);
    import mem_bus_pkg::*;
    import cmpresn_pkg::*;

    logic [size_class_count-1:0] vld_q;          // class has an open zspage
    addr_t                       base_q [size_class_count]; // zspage way address
    addr_t                       fill_q [size_class_count]; // next free byte

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vld_q <= '0;
        end else if (write) begin
            vld_q[lookup_class] <= 1'b1;         // entries are only ever replaced
        end
    end

    always_ff @(posedge clk_i) begin
        if (write) begin
            base_q[lookup_class] <= write_base;
            fill_q[lookup_class] <= write_fill;
        end
    end

    // same-cycle lookup
    assign valid = vld_q[lookup_class];
    assign base  = base_q[lookup_class];
    assign fill  = fill_q[lookup_class];

    // the fill pointer stays inside the zspage it belongs to
    a_fill_in_page : assert property (@(posedge clk_i) disable iff (!rst_ni)
        write |-> (write_fill >= write_base) &&
                  (write_fill <= write_base + addr_t'(page_bytes)));

endmodule

//--- hdl/cmpresn_fsm.sv
module cmpresn_fsm (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                cmpresn_trigger,
    input  mem_bus_pkg::addr_t                  ucmp_head_addr,
    input  logic                                ar_ready,
    input  logic                                r_valid,
    input  logic [mem_bus_pkg::resp_w-1:0]      r_resp,
    input  logic [mem_bus_pkg::data_w-1:0]      r_data,
    input  logic                                rdfifo_full,
    input  logic                                rdfifo_empty,
    input  logic                                comp_done,
    input  logic                                incompressible,
    input  logic [cmpresn_pkg::size_w-1:0]      comp_size,
    input  logic                                pgwr_ready,
    input  logic                                zspg_updated,
    input  logic                                tbl_update_done,
    input  logic                                rd_last,
    input  logic                                uc_valid,
    input  mem_bus_pkg::addr_t                  uc_base,
    input  mem_bus_pkg::addr_t                  uc_fill,
    output logic                                head_ar_valid,
    output mem_bus_pkg::addr_t                  head_ar_addr,
    output logic                                page_read_active,
    output logic                                rd_clear,
    output mem_bus_pkg::way_t                   rd_base,
    output cmpresn_pkg::class_t                 uc_class,
    output logic                                uc_write,
    output mem_bus_pkg::addr_t                  uc_new_base,
    output mem_bus_pkg::addr_t                  uc_new_fill,
    output logic                                comp_start,
    output logic                                zspg_update,
    output mem_bus_pkg::addr_t                  zspg_base,
    output mem_bus_pkg::addr_t                  zspg_cpage_start,
    output logic [cmpresn_pkg::size_w-1:0]      zspg_size,
    output logic                                tbl_update,
    output cmpresn_pkg::list_t                  tbl_src,
    output cmpresn_pkg::list_t                  tbl_dst,
    output mem_bus_pkg::addr_t                  tbl_way_addr,
    output cmpresn_pkg::att_id_t                tbl_att_id,
    output cmpresn_pkg::class_t                 tbl_class,
    output logic                                cmpresn_done,
    output mem_bus_pkg::way_t                   cmpresn_free_way,
    output logic                                bus_error
);
    import mem_bus_pkg::*;
    import cmpresn_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_HEAD_REQ, S_HEAD_WAIT, S_RD_CLEAR, S_PAGE_READ, S_COMP_WAIT,
        S_FILE, S_ZS_WRITE, S_TBL_INCOMP, S_TBL_IFL, S_ERROR, S_BUS_ERR
    } state_t;

    state_t            state_q;
    way_t              ent_way_q;   // decoded list entry
    att_id_t           ent_att_q;
    logic [size_w-1:0] size_q;      // compressed size and its class
    class_t            class_q;
    addr_t             cpage_q;     // where the compressed page lands
    addr_t             zs_base_q;   // zspage holding it
    logic              fits_q;      // appended to an open zspage, frees own way
    addr_t             way_addr;
    logic              fit;
    logic              bad_resp;

    assign way_addr = {ent_way_q, {page_sh{1'b0}}};
    // open zspage of this class has room for the whole page
    assign fit      = uc_valid && (uc_fill + addr_t'(size_q) <= uc_base + addr_t'(page_bytes));
    assign bad_resp = r_valid && (r_resp != resp_okay);

    assign head_ar_valid    = (state_q == S_HEAD_REQ) && ar_ready;
    assign head_ar_addr     = ucmp_head_addr;
    assign page_read_active = (state_q == S_PAGE_READ);  // hands the read port to the counter
    assign rd_clear         = (state_q == S_RD_CLEAR);
    assign rd_base          = ent_way_q;

    // table entry is replaced once the list move is acknowledged
    assign uc_class    = class_q;
    assign uc_write    = (state_q == S_TBL_IFL) && tbl_update && tbl_update_done;
    assign uc_new_base = zs_base_q;
    assign uc_new_fill = cpage_q + addr_t'(size_q);

    assign zspg_base        = zs_base_q;
    assign zspg_cpage_start = cpage_q;
    assign zspg_size        = size_q;

    assign tbl_src      = list_uncomp;                 // always leaves the uncomp list
    assign tbl_dst      = (state_q == S_TBL_INCOMP) ? list_incomp : list_ifl;
    assign tbl_way_addr = (state_q == S_TBL_INCOMP) ? way_addr : cpage_q;
    assign tbl_att_id   = ent_att_q;
    assign tbl_class    = class_q;

    always_ff @(posedge clk_i) begin
        if (state_q == S_HEAD_WAIT && r_valid) begin
            ent_way_q <= r_data[ent_way_w-1:0];
            ent_att_q <= r_data[ent_att_lsb +: att_id_w];
        end
        if (state_q == S_COMP_WAIT && comp_done) begin
            size_q  <= comp_size;
            class_q <= class_t'(comp_size / size_class_bytes);
        end
        if (state_q == S_FILE) begin
            fits_q <= fit;
            if (fit) begin
                cpage_q   <= uc_fill;                  // append behind the last page
                zs_base_q <= uc_base;
            end else begin
                cpage_q   <= way_addr + addr_t'(zs_offset); // new zspage in own way
                zs_base_q <= way_addr;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q          <= S_IDLE;
            comp_start       <= 1'b0;
            zspg_update      <= 1'b0;
            tbl_update       <= 1'b0;
            cmpresn_done     <= 1'b0;
            cmpresn_free_way <= '0;
            bus_error        <= 1'b0;
        end else begin
            cmpresn_done <= 1'b0;                      // single-cycle pulse
            case (state_q)
                S_IDLE: begin
                    if (cmpresn_trigger) begin
                        state_q <= S_HEAD_REQ;
                    end
                end
                S_HEAD_REQ: begin
                    if (ar_ready) begin
                        state_q <= S_HEAD_WAIT;        // strobe goes out this cycle
                    end
                end
                S_HEAD_WAIT: begin
                    if (r_valid) begin
                        state_q <= S_RD_CLEAR;
                    end
                end
                S_RD_CLEAR: begin
                    if (rdfifo_empty) begin            // previous page drained
                        state_q <= S_PAGE_READ;
                    end
                end
                S_PAGE_READ: begin
                    if (rd_last && rdfifo_full) begin
                        comp_start <= 1'b1;
                        state_q    <= S_COMP_WAIT;
                    end
                end
                S_COMP_WAIT: begin
                    if (incompressible) begin
                        comp_start <= 1'b0;
                        state_q    <= S_TBL_INCOMP;
                    end else if (comp_done) begin
                        comp_start <= 1'b0;
                        state_q    <= S_FILE;
                    end
                end
                S_FILE: begin
                    // a fresh zspage must hold metadata and page in one way
                    if (!fit && (int'(size_q) + zs_offset >= page_bytes)) begin
                        state_q <= S_ERROR;
                    end else begin
                        state_q <= S_ZS_WRITE;
                    end
                end
                S_ZS_WRITE: begin
                    if (zspg_update && zspg_updated) begin
                        zspg_update <= 1'b0;
                        state_q     <= S_TBL_IFL;
                    end else if (pgwr_ready) begin
                        zspg_update <= 1'b1;
                    end
                end
                S_TBL_INCOMP, S_TBL_IFL: begin
                    if (tbl_update && tbl_update_done) begin
                        tbl_update <= 1'b0;
                        if (state_q == S_TBL_IFL && fits_q) begin
                            cmpresn_done     <= 1'b1;  // own way is now free
                            cmpresn_free_way <= ent_way_q;
                            state_q          <= S_IDLE;
                        end else begin
                            state_q <= S_HEAD_REQ;     // keep compressing
                        end
                    end else if (pgwr_ready) begin
                        tbl_update <= 1'b1;
                    end
                end
                default: ;                             // error states hold until reset
            endcase
            if (bad_resp) begin
                state_q      <= S_BUS_ERR;
                bus_error    <= 1'b1;
                comp_start   <= 1'b0;
                zspg_update  <= 1'b0;
                tbl_update   <= 1'b0;
                cmpresn_done <= 1'b0;
            end
        end
    end

    // head strobe is single-cycle and only with ar_ready
    a_head_strobe : assert property (@(posedge clk_i) disable iff (!rst_ni)
        head_ar_valid |-> ar_ready && !$past(head_ar_valid));

    // the page writer takes one request at a time
    a_one_writer_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(zspg_update && tbl_update));

endmodule

//--- hdl/cmpresn_mngr.sv
module cmpresn_mngr (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic                           cmpresn_trigger,
    input  mem_bus_pkg::addr_t             ucmp_head_addr,
    input  logic                           ar_ready,
    input  logic                           r_valid,
    input  logic [mem_bus_pkg::resp_w-1:0] r_resp,
    input  logic [mem_bus_pkg::data_w-1:0] r_data,
    input  logic                           rdfifo_full,
    input  logic                           rdfifo_empty,
    input  logic                           comp_done,
    input  logic                           incompressible,
    input  logic [cmpresn_pkg::size_w-1:0] comp_size,
    input  logic                           pgwr_ready,
    input  logic                           zspg_updated,
    input  logic                           tbl_update_done,
    output logic                           ar_valid,
    output mem_bus_pkg::addr_t             ar_addr,
    output logic                           comp_start,
    output logic                           zspg_update,
    output mem_bus_pkg::addr_t             zspg_base,
    output mem_bus_pkg::addr_t             zspg_cpage_start,
    output logic [cmpresn_pkg::size_w-1:0] zspg_size,
    output logic                           tbl_update,
    output cmpresn_pkg::list_t             tbl_src,
    output cmpresn_pkg::list_t             tbl_dst,
    output mem_bus_pkg::addr_t             tbl_way_addr,
    output cmpresn_pkg::att_id_t           tbl_att_id,
    output cmpresn_pkg::class_t            tbl_class,
    output logic                           cmpresn_done,
    output mem_bus_pkg::way_t              cmpresn_free_way,
    output logic                           bus_error
);
    import mem_bus_pkg::*;
    import cmpresn_pkg::*;

    logic   head_ar_valid, beat_ar_valid;    // the two read requesters
    addr_t  head_ar_addr, beat_ar_addr;
    logic   page_read_active;
    logic   rd_clear, rd_last;
    way_t   rd_base;
    class_t uc_class;
    logic   uc_valid, uc_write;
    addr_t  uc_base, uc_fill, uc_new_base, uc_new_fill;

    // beat counter owns the read port only during a page read
    assign ar_valid = page_read_active ? beat_ar_valid : head_ar_valid;
    assign ar_addr  = page_read_active ? beat_ar_addr : head_ar_addr;

    cmpresn_fsm u_fsm (
        .clk_i, .rst_ni, .cmpresn_trigger, .ucmp_head_addr, .ar_ready,
        .r_valid, .r_resp, .r_data, .rdfifo_full, .rdfifo_empty,
        .comp_done, .incompressible, .comp_size,
        .pgwr_ready, .zspg_updated, .tbl_update_done,
        .rd_last, .uc_valid, .uc_base, .uc_fill,
        .head_ar_valid, .head_ar_addr, .page_read_active, .rd_clear, .rd_base,
        .uc_class, .uc_write, .uc_new_base, .uc_new_fill,
        .comp_start, .zspg_update, .zspg_base, .zspg_cpage_start, .zspg_size,
        .tbl_update, .tbl_src, .tbl_dst, .tbl_way_addr, .tbl_att_id, .tbl_class,
        .cmpresn_done, .cmpresn_free_way, .bus_error
    );

    page_read_ctr u_rd_ctr (
        .clk_i, .rst_ni,
        .clear         (rd_clear),
        .base_way      (rd_base),
        .ar_ready, .rdfifo_full, .rdfifo_empty,
        .beat_ar_valid,
        .beat_ar_addr,
        .last          (rd_last)
    );

    uc_way_table u_uc_tbl (
        .clk_i, .rst_ni,
        .lookup_class  (uc_class),
        .write         (uc_write),
        .write_base    (uc_new_base),
        .write_fill    (uc_new_fill),
        .valid         (uc_valid),
        .base          (uc_base),
        .fill          (uc_fill)
    );

endmodule

//--- testbench/tb_cmpresn_mngr.sv
module tb_cmpresn_mngr;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_bus_pkg::*;
    import cmpresn_pkg::*;

    localparam int    n_rows     = 7;
    localparam int    wait_limit = 300;        // cycles allowed for any single wait
    localparam addr_t head_addr  = 48'h0000_8000_0000;

    // one page taken off the uncompressed list
    typedef struct packed {
        way_t              way;
        att_id_t           att;
        logic [size_w-1:0] size;
        logic              incomp;             // compressor gives up
        logic              bad;                // head read answers with a bus fault
    } row_t;

    logic              clk_i, rst_ni, cmpresn_trigger;
    addr_t             ucmp_head_addr;
    logic              ar_ready, r_valid;
    logic [resp_w-1:0] r_resp;
    logic [data_w-1:0] r_data;
    logic              rdfifo_full, rdfifo_empty;
    logic              comp_done, incompressible;
    logic [size_w-1:0] comp_size;
    logic              pgwr_ready, zspg_updated, tbl_update_done;
    logic              ar_valid, comp_start, zspg_update, tbl_update;
    addr_t             ar_addr, zspg_base, zspg_cpage_start, tbl_way_addr;
    logic [size_w-1:0] zspg_size;
    list_t             tbl_src, tbl_dst;
    att_id_t           tbl_att_id;
    class_t            tbl_class;
    logic              cmpresn_done, bus_error;
    way_t              cmpresn_free_way;

    row_t  rows [n_rows];
    logic  zs_open [size_class_count];         // reference copy of the open-zspage table
    addr_t zs_base [size_class_count];
    addr_t zs_fill [size_class_count];
    int    err_cnt;
    int    timeout_cnt;

    cmpresn_mngr cmpresn_mngr_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic next_drive();
        @(posedge clk_i);
        #2;                                     // inputs change just after the edge
    endtask

    task automatic random_delay();
        repeat ($urandom_range(4, 1)) @(posedge clk_i);
        #2;
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            err_cnt++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    function automatic bit over_limit(inout int t, input string what);
        t++;
        if (t <= wait_limit) begin
            return 1'b0;
        end
        timeout_cnt++;
        $display("timeout: no %s within %0d cycles", what, wait_limit);
        return 1'b1;
    endfunction

    task automatic apply_reset();
        rst_ni = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
    endtask

    task automatic check_idle_outputs();
        @(negedge clk_i);
        check_val("ar_valid", 64'(ar_valid), 64'd0);
        check_val("comp_start", 64'(comp_start), 64'd0);
        check_val("zspg_update", 64'(zspg_update), 64'd0);
        check_val("tbl_update", 64'(tbl_update), 64'd0);
        check_val("cmpresn_done", 64'(cmpresn_done), 64'd0);
        check_val("bus_error", 64'(bus_error), 64'd0);
        check_val("cmpresn_free_way", 64'(cmpresn_free_way), 64'd0);
    endtask

    // plays memory, FIFO, compressor and page writer for one list entry
    task automatic run_row(input row_t row, output bit fin);
        addr_t  way_addr, cpage, zbase;
        class_t cls;
        bit     fit;
        int     t, beat, full_hold;

        fin      = 1'b1;                        // fault or timeout ends the run
        way_addr = addr_t'(row.way) * addr_t'(page_bytes);
        cls      = class_t'(row.size / size_class_bytes);
        fit      = zs_open[cls] &&
                   (zs_fill[cls] + addr_t'(row.size) <= zs_base[cls] + addr_t'(page_bytes));
        cpage    = fit ? zs_fill[cls] : way_addr + addr_t'(zs_offset);
        zbase    = fit ? zs_base[cls] : way_addr;
        t = 0;
        do begin
            @(negedge clk_i);
        end while (!ar_valid && !over_limit(t, "head read"));
        if (!ar_valid) return;
        check_val("ar_addr", 64'(ar_addr), 64'(head_addr));
        random_delay();
        r_valid = 1'b1;
        r_resp  = row.bad ? 2'd2 : resp_okay;
        r_data  = {12'h000, row.att, row.way}; // list entry of this row
        next_drive();
        r_valid = 1'b0;
        r_resp  = resp_okay;
        if (row.bad) begin
            repeat (20) begin                   // sticky until reset, never done
                @(negedge clk_i);
                check_val("bus_error", 64'(bus_error), 64'd1);
                check_val("cmpresn_done", 64'(cmpresn_done), 64'd0);
            end
            return;
        end
        beat      = 0;
        full_hold = 0;
        t         = 0;
        while (beat < beats_per_page) begin
            @(negedge clk_i);
            assert (!(ar_valid && rdfifo_full)) else begin
                err_cnt++;
                $display("read request issued at %0t while the read FIFO was full", $time);
            end
            if (ar_valid) begin
                check_val("ar_addr", 64'(ar_addr), 64'(way_addr + addr_t'(beat * beat_bytes)));
                beat++;
                if (beat == 20) begin
                    full_hold = 3;              // FIFO stalls mid page
                end
            end else if (over_limit(t, "page read beat")) begin
                return;
            end
            next_drive();
            rdfifo_empty = (beat == 0);
            rdfifo_full  = (full_hold > 0) || (beat == beats_per_page);
            if (full_hold > 0) begin
                full_hold--;
            end
        end
        t = 0;
        do begin
            @(negedge clk_i);
        end while (!comp_start && !over_limit(t, "comp_start"));
        if (!comp_start) return;
        random_delay();
        incompressible = row.incomp;
        comp_done      = !row.incomp;
        comp_size      = row.size;
        next_drive();
        incompressible = 1'b0;
        comp_done      = 1'b0;
        rdfifo_full    = 1'b0;                  // compressor drained the FIFO
        rdfifo_empty   = 1'b1;
        @(negedge clk_i);
        check_val("comp_start", 64'(comp_start), 64'd0);
        if (!row.incomp) begin
            t = 0;
            do begin
                @(negedge clk_i);
            end while (!zspg_update && !over_limit(t, "zspg_update"));
            if (!zspg_update) return;
            check_val("zspg_base", 64'(zspg_base), 64'(zbase));
            check_val("zspg_cpage_start", 64'(zspg_cpage_start), 64'(cpage));
            check_val("zspg_size", 64'(zspg_size), 64'(row.size));
            random_delay();
            zspg_updated = 1'b1;
            next_drive();
            zspg_updated = 1'b0;
            @(negedge clk_i);
            check_val("zspg_update", 64'(zspg_update), 64'd0);
        end
        t = 0;
        do begin
            @(negedge clk_i);
        end while (!tbl_update && !over_limit(t, "tbl_update"));
        if (!tbl_update) return;
        check_val("tbl_src", 64'(tbl_src), 64'(list_uncomp));
        check_val("tbl_dst", 64'(tbl_dst), 64'(row.incomp ? list_incomp : list_ifl));
        check_val("tbl_way_addr", 64'(tbl_way_addr), 64'(row.incomp ? way_addr : cpage));
        check_val("tbl_att_id", 64'(tbl_att_id), 64'(row.att));
        if (!row.incomp) begin
            check_val("tbl_class", 64'(tbl_class), 64'(cls));
            zs_open[cls] = 1'b1;                // entry replaced or advanced
            zs_base[cls] = zbase;
            zs_fill[cls] = cpage + addr_t'(row.size);
        end
        random_delay();
        tbl_update_done = 1'b1;
        next_drive();
        tbl_update_done = 1'b0;
        if (row.incomp || !fit) begin
            fin = 1'b0;                         // manager goes on with the next head
            return;
        end
        t = 0;
        do begin
            @(negedge clk_i);
        end while (!cmpresn_done && !over_limit(t, "cmpresn_done"));
        if (!cmpresn_done) return;
        check_val("cmpresn_free_way", 64'(cmpresn_free_way), 64'(row.way));
        @(negedge clk_i);
        check_val("cmpresn_done", 64'(cmpresn_done), 64'd0);   // single cycle
    endtask

    initial begin
        bit fin;
        int row;

        void'($urandom(32'h9888));
        err_cnt = 0;
        timeout_cnt = 0;
        // way, attribute id, size, incompressible, bad response
        rows[0] = '{36'h10, 16'h1111, 14'd300, 1'b1, 1'b0};
        rows[1] = '{36'h11, 16'h2222, 14'd1000, 1'b0, 1'b0};  // opens class 1
        rows[2] = '{36'h12, 16'h3333, 14'd700, 1'b0, 1'b0};   // appends, done
        rows[3] = '{36'h20, 16'h4444, 14'd3000, 1'b0, 1'b0};  // opens class 5
        rows[4] = '{36'h21, 16'h5555, 14'd2900, 1'b0, 1'b0};  // too big, reopens class 5
        rows[5] = '{36'h22, 16'h6666, 14'd520, 1'b0, 1'b0};   // appends to class 1
        rows[6] = '{36'h30, 16'h7777, 14'd100, 1'b0, 1'b1};
        for (int c = 0; c < size_class_count; c++) begin
            zs_open[c] = 1'b0;
            zs_base[c] = '0;
            zs_fill[c] = '0;
        end
        cmpresn_trigger = 1'b0;
        ucmp_head_addr  = head_addr;
        ar_ready        = 1'b1;
        r_valid         = 1'b0;
        r_resp          = resp_okay;
        r_data          = '0;
        rdfifo_full     = 1'b0;
        rdfifo_empty    = 1'b1;
        comp_done       = 1'b0;
        incompressible  = 1'b0;
        comp_size       = '0;
        pgwr_ready      = 1'b1;
        zspg_updated    = 1'b0;
        tbl_update_done = 1'b0;
        apply_reset();
        check_idle_outputs();
        row = 0;
        while (row < n_rows && timeout_cnt == 0) begin
            next_drive();
            cmpresn_trigger = 1'b1;             // one trigger runs rows until done
            next_drive();
            cmpresn_trigger = 1'b0;
            fin = 1'b0;
            while (!fin && row < n_rows) begin
                run_row(rows[row], fin);
                row++;
            end
        end
        next_drive();
        apply_reset();                          // clears the sticky bus error
        check_idle_outputs();
        $display("errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/mem_bus_pkg.sv
hdl/cmpresn_pkg.sv
hdl/page_read_ctr.sv
hdl/uc_way_table.sv
hdl/cmpresn_fsm.sv
hdl/cmpresn_mngr.sv
testbench/tb_cmpresn_mngr.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the compression manager testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_cmpresn_mngr -Mdir obj_dir -o tb_sim -f build.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1
